// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_ddr3_write_top
RTL_TOP    := ddr3_write_top
FILELIST   := files.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
verilog/ddr3_write_pkg.sv
verilog/ddr3_write_ifs.sv
verilog/fifo_ddr3_write.sv
verilog/wr_burst_split.sv
verilog/ddr3_write.sv
verilog/ddr3_write_top.sv
sim/ddr_port_model.sv
sim/tb_ddr3_write_top.sv

// ==== sim/ddr_port_model.sv ====
module ddr_port_model
    import ddr3_write_pkg::*;
(
    input  logic                   clk,
    input  logic                   ddr_rstn_sync,
    input  logic [addr_w-1:0]      write_addr,
    input  logic [chunk_len_w-1:0] write_len,
    input  logic                   write_addr_valid,
    output logic                   write_addr_ready,
    input  logic [beat_w-1:0]      write_data,
    input  logic [strb_w-1:0]      write_strb,
    output logic                   write_data_ready,
    output logic                   write_data_last
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int mem_words = 8192;

    logic [word_w-1:0]      mem [mem_words];  // filled by the testbench at start
    logic                   busy;             // chunk accepted, beats still owed
    logic [addr_w-1:0]      beat_addr;
    logic [chunk_len_w-1:0] beat_idx;
    logic [chunk_len_w-1:0] last_idx;
    int                     seed;

    // ready levels change on the falling edge only
    initial begin
        seed             = 59;
        write_addr_ready = 1'b0;
        write_data_ready = 1'b0;
        write_data_last  = 1'b0;
        forever begin
            @(negedge clk);
            write_addr_ready = ddr_rstn_sync && !busy && (($random(seed) & 3) != 0);
            write_data_ready = ddr_rstn_sync && busy && (($random(seed) & 3) != 0);
            write_data_last  = busy && (beat_idx == last_idx); // beat number write_len
        end
    end

    always @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            busy      <= 1'b0;
            beat_addr <= '0;
            beat_idx  <= '0;
            last_idx  <= '0;
        end else begin
            if (write_addr_valid && write_addr_ready) begin
                busy      <= 1'b1;
                beat_addr <= write_addr;
                beat_idx  <= '0;
                last_idx  <= write_len;
            end
            if (write_data_ready) begin
                for (int b = 0; b < strb_w; b++) begin
                    if (write_strb[b]) begin
                        mem[(int'(beat_addr) + b / 4) % mem_words][8*(b%4) +: 8] =
                            write_data[8*b +: 8];  // only strobed bytes land
                    end
                end
                beat_addr <= beat_addr + addr_w'(beat_words);
                beat_idx  <= beat_idx + 1'b1;
                busy      <= !write_data_last;
            end
        end
    end

endmodule

// ==== sim/tb_ddr3_write_top.sv ====
module tb_ddr3_write_top
    import ddr3_write_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_bursts  = 40;
    localparam int cycle_cap = n_bursts * 2400;  // generous budget per burst
    localparam int mem_words = 8192;
    localparam int win_words = 4096;

    logic                   clk;
    logic                   ddr_rstn_sync;
    logic [id_w-1:0]        aw_id;
    logic [addr_w-1:0]      aw_addr;
    logic [axi_len_w-1:0]   aw_len;
    logic [1:0]             aw_burst;
    logic                   aw_valid, aw_ready;
    logic [word_w-1:0]      w_data;
    logic [wstrb_w-1:0]     w_strb;
    logic                   w_last, w_valid, w_ready;
    logic [id_w-1:0]        b_id;
    logic [1:0]             b_resp;
    logic                   b_valid, b_ready;
    logic [addr_w-1:0]      write_addr;
    logic [chunk_len_w-1:0] write_len;
    logic [id_w-1:0]        write_id;
    logic                   write_addr_valid, write_addr_ready;
    logic [beat_w-1:0]      write_data;
    logic [strb_w-1:0]      write_strb;
    logic                   write_data_ready, write_data_last;

    logic [word_w-1:0]     ref_mem [mem_words];
    logic [addr_w-1:0]     first_beat, last_beat;  // beat addresses at the burst ends
    logic [addr_w-1:0]     next_chunk;
    logic [addr_w-1:0]     beat_addr;
    logic [beat_off_w-1:0] start_off, end_off;
    logic [id_w-1:0]       cur_id;
    logic                  b_held = 1'b0;
    logic                  addr_held = 1'b0;
    int                    seed;
    int                    errors = 0;
    int                    failed = 0;
    int                    cycles = 0;
    int                    b_count = 0;
    int                    beats_total, beats_left, beats_pulled;

    ddr3_write_top i_dut (.*);
    ddr_port_model i_port (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [word_w-1:0] fill_word(input int a);
        return word_w'(a) * 32'h9E37_79B1 ^ 32'h5A5A_0F0F;
    endfunction

    function automatic void expect_bit(input string name, input logic got, input logic want);
        assert (got === want) else begin
            $display("MISMATCH %s: got %h expected %h", name, got, want);
            errors++;
        end
    endfunction

    // up to 16 beats per chunk, 8 words a beat
    function automatic void track_chunk();
        int want;
        want = (beats_left > max_chunk_beats) ? max_chunk_beats : beats_left;
        assert (write_addr == next_chunk && write_addr[beat_off_w-1:0] == '0) else begin
            $display("MISMATCH write_addr: got %h expected %h", write_addr, next_chunk);
            errors++;
        end
        assert (int'(write_len) + 1 == want) else begin
            $display("MISMATCH write_len: got %h expected %h", write_len, want - 1);
            errors++;
        end
        assert (write_id == cur_id) else begin
            $display("MISMATCH write_id: got %h expected %h", write_id, cur_id);
            errors++;
        end
        next_chunk = next_chunk + (addr_w'(write_len) + 1'b1) * addr_w'(beat_words);
        beats_left = beats_left - (int'(write_len) + 1);
        beat_addr  = write_addr;
    endfunction

    function automatic void inspect_beat();
        for (int k = 0; k < beat_words; k++) begin
            if ((beat_addr == first_beat && k < int'(start_off))
                || (beat_addr == last_beat && k > int'(end_off))) begin
                assert (write_strb[k*wstrb_w +: wstrb_w] == '0) else begin
                    $display("MISMATCH write_strb at %h lane %0d: got %h expected 0",
                             beat_addr, k, write_strb[k*wstrb_w +: wstrb_w]);
                    errors++;
                end
            end
        end
        beats_pulled++;
        beat_addr = beat_addr + addr_w'(beat_words);
    endfunction

    function automatic void score_response();
        b_count++;
        assert (b_id == cur_id) else begin
            $display("MISMATCH b_id: got %h expected %h", b_id, cur_id);
            errors++;
        end
        assert (b_resp == 2'b00) else begin
            $display("MISMATCH b_resp: got %h expected 0", b_resp);
            errors++;
        end
        assert (beats_left == 0 && beats_pulled == beats_total) else begin
            $display("response came before all %0d native beats were written", beats_total);
            errors++;
        end
    endfunction

    // monitor sees the values from before the edge
    always @(posedge clk) begin
        if (ddr_rstn_sync) begin
            assert (!b_held || b_valid) else begin
                $display("b_valid fell before its handshake");
                errors++;
            end
            assert (!addr_held || write_addr_valid) else begin
                $display("write_addr_valid fell before its handshake");
                errors++;
            end
            b_held    = b_valid && !b_ready;
            addr_held = write_addr_valid && !write_addr_ready;
            if (write_addr_valid && write_addr_ready) track_chunk();
            if (write_data_ready) inspect_beat();
            if (b_valid && b_ready) score_response();
        end
    end

    initial begin
        while (cycles < cycle_cap) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not end within %0d cycles", cycle_cap);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic run_burst(input int k);
        logic [addr_w-1:0]    addr;
        logic [addr_w-1:0]    last_addr;
        logic [axi_len_w-1:0] len;
        int                   err_before;
        int                   idx;
        bit                   done;
        err_before   = errors;
        cur_id       = id_w'($random(seed));
        addr         = addr_w'($random(seed)) & addr_w'(win_words - 1);
        len          = axi_len_w'($random(seed));
        last_addr    = addr + addr_w'(len);
        start_off    = addr[beat_off_w-1:0];
        end_off      = last_addr[beat_off_w-1:0];
        first_beat   = {addr[addr_w-1:beat_off_w], beat_off_w'(0)};
        last_beat    = {last_addr[addr_w-1:beat_off_w], beat_off_w'(0)};
        next_chunk   = first_beat;
        beats_total  = int'((last_beat - first_beat) >> beat_off_w) + 1;
        beats_left   = beats_total;
        beats_pulled = 0;
        aw_id        = cur_id;
        aw_addr      = addr;
        aw_len       = len;
        aw_valid     = 1'b1;
        do @(posedge clk); while (!aw_ready);
        @(negedge clk);
        aw_valid = 1'b0;
        for (int i = 0; i <= int'(len); i++) begin
            if (($random(seed) & 3) == 0) begin  // idle gap before this word
                w_valid = 1'b0;
                repeat (1 + ($random(seed) & 3)) @(negedge clk);
            end
            w_data  = $random(seed);
            w_strb  = wstrb_w'($random(seed));
            w_last  = (i == int'(len));
            w_valid = 1'b1;
            do @(posedge clk); while (!w_ready);
            idx = (int'(addr) + i) % mem_words;
            for (int b = 0; b < wstrb_w; b++) begin
                if (w_strb[b]) ref_mem[idx][8*b +: 8] = w_data[8*b +: 8];
            end
            @(negedge clk);
        end
        w_valid = 1'b0;
        w_last  = 1'b0;
        done    = 1'b0;
        while (!done) begin
            b_ready = ($random(seed) & 1) != 0;
            @(posedge clk);
            done = b_valid && b_ready;
            @(negedge clk);
        end
        b_ready = 1'b0;
        for (int a = int'(first_beat); a < int'(last_beat) + beat_words; a++) begin
            assert (i_port.mem[a % mem_words] == ref_mem[a % mem_words]) else begin
                $display("MISMATCH mem[%h]: got %h expected %h", a,
                         i_port.mem[a % mem_words], ref_mem[a % mem_words]);
                errors++;
            end
        end
        assert (b_count == k + 1) else begin
            $display("burst %0d saw %0d responses in total, expected %0d", k, b_count, k + 1);
            errors++;
        end
        if (errors != err_before) failed++;
        $display("burst %2d id %h addr %h len %3d beats %2d: %s", k, cur_id, addr, len,
                 beats_total, (errors == err_before) ? "ok" : "FAILED");
    endtask

    initial begin
        seed          = 59;
        ddr_rstn_sync = 1'b0;
        aw_id         = '0;
        aw_addr       = '0;
        aw_len        = '0;
        aw_burst      = 2'b01;  // incremental
        aw_valid      = 1'b0;
        w_data        = '0;
        w_strb        = '0;
        w_last        = 1'b0;
        w_valid       = 1'b0;
        b_ready       = 1'b0;
        for (int a = 0; a < mem_words; a++) begin
            ref_mem[a]    = fill_word(a);
            i_port.mem[a] = fill_word(a);
        end
        repeat (5) @(negedge clk);
        ddr_rstn_sync = 1'b1;
        @(posedge clk);
        expect_bit("aw_ready", aw_ready, 1'b1);
        expect_bit("w_ready", w_ready, 1'b0);
        expect_bit("b_valid", b_valid, 1'b0);
        expect_bit("write_addr_valid", write_addr_valid, 1'b0);
        if (errors != 0) failed++;
        $display("reset state: %s", (errors == 0) ? "ok" : "FAILED");
        @(negedge clk);
        for (int k = 0; k < n_bursts; k++) run_burst(k);
        do @(posedge clk); while (!aw_ready);  // last flush over
        assert (b_count == n_bursts) else begin
            $display("saw %0d responses for %0d bursts", b_count, n_bursts);
            errors++;
        end
        $display("%0d tests run, %0d failed, %0d errors", n_bursts + 1, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== verilog/ddr3_write.sv ====
module ddr3_write
    import ddr3_write_pkg::*;
(
    input  logic                   clk,
    input  logic                   ddr_rstn_sync,
    input  logic [id_w-1:0]        aw_id,
    input  logic [addr_w-1:0]      aw_addr,
    input  logic [axi_len_w-1:0]   aw_len,
    input  logic [1:0]             aw_burst,          // incremental assumed, not decoded
    input  logic                   aw_valid,
    output logic                   aw_ready,
    input  logic [word_w-1:0]      w_data,
    input  logic [wstrb_w-1:0]     w_strb,
    input  logic                   w_last,
    input  logic                   w_valid,
    output logic                   w_ready,
    output logic [id_w-1:0]        b_id,
    output logic [1:0]             b_resp,
    output logic                   b_valid,
    input  logic                   b_ready,
    output logic [addr_w-1:0]      write_addr,
    output logic [chunk_len_w-1:0] write_len,
    output logic [id_w-1:0]        write_id,
    output logic                   write_addr_valid,
    input  logic                   write_addr_ready,
    output logic [beat_w-1:0]      write_data,
    output logic [strb_w-1:0]      write_strb,
    input  logic                   write_data_ready,
    input  logic                   write_data_last
);

    wr_state_t              state;
    wr_state_t              state_nxt;
    logic [beat_off_w-1:0]  lead_pad;     // pads still owed before the first word
    logic [beat_off_w-1:0]  trail_pad;    // pads owed after the last word
    logic [beat_off_w-1:0]  end_off;
    logic                   last_rcvd;
    logic [flush_cnt_w-1:0] flush_cnt;
    logic                   aw_hs;
    logic                   w_hs;
    logic                   b_hs;
    logic                   addr_hs;
    logic                   beat_end;
    logic                   lead_wr;
    logic                   trail_wr;
    logic                   pad_wr;

    fifo_port_if  fifo_bus ();
    burst_plan_if plan_bus ();

    fifo_ddr3_write i_fifo (
        .clk           (clk),
        .ddr_rstn_sync (ddr_rstn_sync),
        .fp            (fifo_bus.fifo)
    );

    wr_burst_split i_split (
        .clk           (clk),
        .ddr_rstn_sync (ddr_rstn_sync),
        .bp            (plan_bus.plan)
    );

    assign aw_hs    = aw_valid && aw_ready;
    assign w_hs     = w_valid && w_ready;
    assign b_hs     = b_valid && b_ready;
    assign addr_hs  = write_addr_valid && write_addr_ready;
    assign beat_end = (state == st_trans_data) && write_data_ready && write_data_last;

    assign end_off  = aw_addr[beat_off_w-1:0] + aw_len[beat_off_w-1:0];  // wraps in the beat

    assign lead_wr  = (state == st_wait) && (lead_pad != '0);
    assign trail_wr = (state == st_after) && (trail_pad != '0);
    assign pad_wr   = lead_wr || trail_wr;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (aw_hs) begin
                    state_nxt = st_wait;
                end
            end
            st_wait: begin
                if (fifo_bus.level >= level_w'(chunk_words)) begin
                    state_nxt = st_trans_addr;  // a full chunk is buffered
                end else if (last_rcvd) begin
                    state_nxt = st_after;
                end
            end
            st_trans_addr: begin
                if (addr_hs) begin
                    state_nxt = st_trans_data;
                end
            end
            st_trans_data: begin
                if (beat_end) begin
                    // all words and pads are buffered, send the rest back to back
                    if (plan_bus.more_chunks && last_rcvd && (trail_pad == '0)) begin
                        state_nxt = st_trans_addr;
                    end else if (plan_bus.more_chunks) begin
                        state_nxt = st_wait;
                    end else begin
                        state_nxt = st_resp;
                    end
                end
            end
            st_after: begin
                if (trail_pad == '0) begin
                    state_nxt = st_trans_addr;
                end
            end
            st_resp: begin
                if (b_hs) begin
                    state_nxt = st_flush;
                end
            end
            st_flush: begin
                if (flush_cnt == flush_cnt_w'(flush_cycles - 1)) begin
                    state_nxt = st_idle;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            state     <= st_idle;
            lead_pad  <= '0;
            trail_pad <= '0;
            last_rcvd <= 1'b0;
            flush_cnt <= '0;
        end else begin
            state <= state_nxt;

            if (aw_hs) begin
                lead_pad <= aw_addr[beat_off_w-1:0];
            end else if (lead_wr) begin
                lead_pad <= lead_pad - 1'b1;
            end

            if (aw_hs) begin
                trail_pad <= beat_off_w'(beat_words - 1) - end_off;
            end else if (trail_wr) begin
                trail_pad <= trail_pad - 1'b1;
            end

            if (state == st_idle) begin
                last_rcvd <= 1'b0;
            end else if (w_hs && w_last) begin
                last_rcvd <= 1'b1;
            end

            if (state == st_flush) begin
                flush_cnt <= flush_cnt + 1'b1;
            end else begin
                flush_cnt <= '0;
            end
        end
    end

    // AXI handshakes
    assign aw_ready = (state == st_idle);
    assign w_ready  = ((state == st_wait) || (state == st_trans_data))
                    && (lead_pad == '0) && !fifo_bus.almost_full && !last_rcvd;
    assign b_valid  = (state == st_resp);
    assign b_id     = plan_bus.burst_id;
    assign b_resp   = 2'b00;  // OKAY only

    // FIFO write side, pads or AXI words
    assign fifo_bus.wr_en   = pad_wr || w_hs;
    assign fifo_bus.wr_data = pad_wr ? pad_word : w_data;
    assign fifo_bus.wr_strb = pad_wr ? '0 : w_strb;
    assign fifo_bus.rd_en   = (state == st_trans_data) && write_data_ready
                            && fifo_bus.beat_ready;
    assign fifo_bus.flush   = (state == st_flush);

    assign plan_bus.load        = aw_hs;
    assign plan_bus.start_addr  = aw_addr;
    assign plan_bus.axi_len     = aw_len;
    assign plan_bus.id          = aw_id;
    assign plan_bus.chunk_taken = addr_hs;

    // native port
    assign write_addr       = plan_bus.chunk_addr;
    assign write_len        = plan_bus.chunk_len;
    assign write_id         = plan_bus.burst_id;
    assign write_addr_valid = (state == st_trans_addr);
    assign write_data       = fifo_bus.rd_data;
    assign write_strb       = fifo_bus.rd_strb;

endmodule

// ==== verilog/ddr3_write_ifs.sv ====
interface fifo_port_if
    import ddr3_write_pkg::*;
();
    logic                 wr_en;
    logic [word_w-1:0]    wr_data;
    logic [wstrb_w-1:0]   wr_strb;
    logic                 rd_en;     // pops a whole beat
    logic                 flush;
    logic [beat_w-1:0]    rd_data;   // oldest word in low slice
    logic [strb_w-1:0]    rd_strb;
    logic [level_w-1:0]   level;     // in words
    logic                 almost_full;
    logic                 beat_ready;

    modport fifo (input wr_en, wr_data, wr_strb, rd_en, flush,
                  output rd_data, rd_strb, level, almost_full, beat_ready);
    modport ctrl (output wr_en, wr_data, wr_strb, rd_en, flush,
                  input rd_data, rd_strb, level, almost_full, beat_ready);
endinterface

interface burst_plan_if
    import ddr3_write_pkg::*;
();
    logic                   load;        // aw handshake
    logic [addr_w-1:0]      start_addr;
    logic [axi_len_w-1:0]   axi_len;
    logic [id_w-1:0]        id;
    logic                   chunk_taken; // native address handshake
    logic [addr_w-1:0]      chunk_addr;
    logic [chunk_len_w-1:0] chunk_len;
    logic [id_w-1:0]        burst_id;
    logic                   more_chunks;

    modport plan (input load, start_addr, axi_len, id, chunk_taken,
                  output chunk_addr, chunk_len, burst_id, more_chunks);
    modport ctrl (output load, start_addr, axi_len, id, chunk_taken,
                  input chunk_addr, chunk_len, burst_id, more_chunks);
endinterface

// ==== verilog/ddr3_write_pkg.sv ====
package ddr3_write_pkg;

    // addresses count 32-bit words on both sides
    localparam int addr_w      = 28;
    localparam int axi_len_w   = 8;    // burst length minus one
    localparam int id_w        = 4;
    localparam int word_w      = 32;
    localparam int wstrb_w     = word_w / 8;

    localparam int beat_words  = 8;                   // words per native beat
    localparam int beat_w      = word_w * beat_words; // 256
    localparam int strb_w      = beat_w / 8;          // 32
    localparam int beat_off_w  = 3;                   // word offset inside a beat

    localparam int max_chunk_beats = 16;
    localparam int chunk_len_w     = 4;  // chunk length minus one
    localparam int beat_cnt_w      = 6;  // a 256-word burst spans up to 33 beats

    localparam int fifo_words        = 256;
    localparam int fifo_addr_w       = 8;
    localparam int fifo_beat_w       = fifo_addr_w - beat_off_w;
    localparam int level_w           = 9;
    localparam int almost_full_words = 248; // AXI data refused from here
    localparam int chunk_words       = 128; // one full 16-beat chunk

    localparam int flush_cycles = 15;
    localparam int flush_cnt_w  = 4;

    localparam logic [word_w-1:0] pad_word = 32'h1234_5678; // filler under zero strobes

    typedef enum logic [2:0] {
        st_idle       = 3'd0,
        st_wait       = 3'd1,  // collect AXI words
        st_trans_addr = 3'd2,
        st_trans_data = 3'd3,
        st_after      = 3'd4,  // trailing pads
        st_resp       = 3'd5,
        st_flush      = 3'd6
    } wr_state_t;

endpackage

// ==== verilog/ddr3_write_top.sv ====
module ddr3_write_top
    import ddr3_write_pkg::*;
(
    input  logic                   clk,
    input  logic                   ddr_rstn_sync,
    // AXI write address
    input  logic [id_w-1:0]        aw_id,
    input  logic [addr_w-1:0]      aw_addr,
    input  logic [axi_len_w-1:0]   aw_len,
    input  logic [1:0]             aw_burst,
    input  logic                   aw_valid,
    output logic                   aw_ready,
    // AXI write data
    input  logic [word_w-1:0]      w_data,
    input  logic [wstrb_w-1:0]     w_strb,
    input  logic                   w_last,
    input  logic                   w_valid,
    output logic                   w_ready,
    // AXI write response
    output logic [id_w-1:0]        b_id,
    output logic [1:0]             b_resp,
    output logic                   b_valid,
    input  logic                   b_ready,
    // native write port
    output logic [addr_w-1:0]      write_addr,
    output logic [chunk_len_w-1:0] write_len,
    output logic [id_w-1:0]        write_id,
    output logic                   write_addr_valid,
    input  logic                   write_addr_ready,
    output logic [beat_w-1:0]      write_data,
    output logic [strb_w-1:0]      write_strb,
    input  logic                   write_data_ready,
    input  logic                   write_data_last
);

    ddr3_write i_write (
        .clk              (clk),
        .ddr_rstn_sync    (ddr_rstn_sync),
        .aw_id            (aw_id),
        .aw_addr          (aw_addr),
        .aw_len           (aw_len),
        .aw_burst         (aw_burst),
        .aw_valid         (aw_valid),
        .aw_ready         (aw_ready),
        .w_data           (w_data),
        .w_strb           (w_strb),
        .w_last           (w_last),
        .w_valid          (w_valid),
        .w_ready          (w_ready),
        .b_id             (b_id),
        .b_resp           (b_resp),
        .b_valid          (b_valid),
        .b_ready          (b_ready),
        .write_addr       (write_addr),
        .write_len        (write_len),
        .write_id         (write_id),
        .write_addr_valid (write_addr_valid),
        .write_addr_ready (write_addr_ready),
        .write_data       (write_data),
        .write_strb       (write_strb),
        .write_data_ready (write_data_ready),
        .write_data_last  (write_data_last)
    );

endmodule

// ==== verilog/fifo_ddr3_write.sv ====
module fifo_ddr3_write
    import ddr3_write_pkg::*;
(
    input logic       clk,
    input logic       ddr_rstn_sync,
    fifo_port_if.fifo fp
);

    logic [wstrb_w+word_w-1:0] mem [fifo_words];  // {strb, data} per word
    logic [fifo_addr_w-1:0]    wr_ptr;            // word steps
    logic [fifo_beat_w-1:0]    rd_ptr;            // beat steps
    logic [level_w-1:0]        level;

    always_ff @(posedge clk) begin
        if (fp.wr_en) begin
            mem[wr_ptr] <= {fp.wr_strb, fp.wr_data};
        end
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else if (fp.flush) begin
            wr_ptr <= '0;  // beats stay aligned to entry 0
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (fp.wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fp.rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            level <= level + level_w'(fp.wr_en)
                   - (fp.rd_en ? level_w'(beat_words) : level_w'(0));
        end
    end

    // the next eight entries seen as one beat
    always_comb begin
        logic [wstrb_w+word_w-1:0] entry;
        entry = '0;
        for (int k = 0; k < beat_words; k++) begin
            entry = mem[{rd_ptr, beat_off_w'(k)}];
            fp.rd_data[k*word_w +: word_w]    = entry[word_w-1:0];
            fp.rd_strb[k*wstrb_w +: wstrb_w]  = entry[word_w +: wstrb_w];
        end
    end

    assign fp.level       = level;
    assign fp.almost_full = level >= level_w'(almost_full_words);
    assign fp.beat_ready  = level >= level_w'(beat_words);

endmodule

// ==== verilog/wr_burst_split.sv ====
module wr_burst_split
    import ddr3_write_pkg::*;
(
    input logic        clk,
    input logic        ddr_rstn_sync,
    burst_plan_if.plan bp
);

    logic [addr_w-1:0]     addr_q;       // next chunk address, beat aligned
    logic [id_w-1:0]       id_q;
    logic [beat_cnt_w-1:0] beats_left;
    logic [addr_w-1:0]     end_addr;
    logic [beat_cnt_w-1:0] burst_beats;
    logic [beat_cnt_w-1:0] chunk_beats;

    assign end_addr = bp.start_addr + addr_w'(bp.axi_len);

    // end beat index minus start beat index plus one
    assign burst_beats = beat_cnt_w'(end_addr[addr_w-1:beat_off_w]
                                   - bp.start_addr[addr_w-1:beat_off_w]) + 1'b1;

    assign chunk_beats = (beats_left > beat_cnt_w'(max_chunk_beats))
                       ? beat_cnt_w'(max_chunk_beats) : beats_left;

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            beats_left <= '0;
        end else if (bp.load) begin
            beats_left <= burst_beats;
        end else if (bp.chunk_taken) begin
            beats_left <= beats_left - chunk_beats;
        end
    end

    always_ff @(posedge clk) begin
        if (bp.load) begin
            addr_q <= {bp.start_addr[addr_w-1:beat_off_w], beat_off_w'(0)};
            id_q   <= bp.id;
        end else if (bp.chunk_taken) begin
            addr_q <= addr_q + (addr_w'(chunk_beats) << beat_off_w); // 8 words a beat
        end
    end

    assign bp.chunk_addr  = addr_q;
    assign bp.chunk_len   = chunk_len_w'(chunk_beats - 1'b1);
    assign bp.burst_id    = id_q;
    // after the address handshake this counts beats beyond the chunk in flight
    assign bp.more_chunks = beats_left != '0;

endmodule
